/* src/stream_axil_settings.svh */
/*
 * Build-time widths, register count and decode base for the stream to AXI-Lite bridge.
 * Included by the package and by every module that sizes a port or decodes an address.
 */

`ifndef STREAM_AXIL_SETTINGS_SVH
`define STREAM_AXIL_SETTINGS_SVH

// Bus address and data widths
`define STREAM_AXIL_ADDR_W 32
`define STREAM_AXIL_DATA_W 32

// Number of word registers in the bank
`define STREAM_AXIL_REG_COUNT 16

// Byte address of register 0, registers follow on word boundaries
`define STREAM_AXIL_REG_BASE 32'h0000_1000

`endif

/* src/stream_axil_pkg.sv */
/*
 * Shared stream payloads, AXI-Lite channel bundles and FSM encodings.
 * Modules refer to these by scoped name.
 */

`include "stream_axil_settings.svh"

package stream_axil_pkg;

    typedef struct packed {
        logic [`STREAM_AXIL_ADDR_W-1:0] addr;
        logic [`STREAM_AXIL_DATA_W-1:0] data;
    } write_word_t;

    typedef struct packed {
        logic [`STREAM_AXIL_DATA_W-1:0] data;
        logic                           error;
    } read_resp_t;

    // Encodings follow the AXI response field
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axil_resp_t;

    // Everything the manager side drives
    typedef struct packed {
        logic                           awvalid;
        logic [`STREAM_AXIL_ADDR_W-1:0] awaddr;
        logic                           wvalid;
        logic [`STREAM_AXIL_DATA_W-1:0] wdata;
        logic                           bready;
        logic                           arvalid;
        logic [`STREAM_AXIL_ADDR_W-1:0] araddr;
        logic                           rready;
    } axil_req_t;

    // Everything the register bank drives
    typedef struct packed {
        logic                           awready;
        logic                           wready;
        logic                           bvalid;
        axil_resp_t                     bresp;
        logic                           arready;
        logic                           rvalid;
        logic [`STREAM_AXIL_DATA_W-1:0] rdata;
        axil_resp_t                     rresp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        writer_idle,
        writer_send_address,
        writer_send_data,
        writer_wait_response
    } writer_state_t;

    typedef enum logic [1:0] {
        reader_idle,
        reader_send_address,
        reader_wait_data
    } reader_state_t;

endpackage

/* src/axil_bridge_ctrl.sv */
/*
 * Bridge FSMs that turn the write stream and the read request stream into AXI-Lite
 * transactions, report write completion and hand read data to the response buffer.
 */

`include "stream_axil_settings.svh"

module axil_bridge_ctrl (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           write_valid,
    input  stream_axil_pkg::write_word_t   write_word,
    output logic                           write_ready,
    input  logic                           read_req_valid,
    input  logic [`STREAM_AXIL_ADDR_W-1:0] read_req_addr,
    output logic                           read_req_ready,
    output stream_axil_pkg::axil_req_t     bus_req,
    input  stream_axil_pkg::axil_rsp_t     bus_rsp,
    output logic                           write_done,
    output logic                           write_error,
    input  logic                           rd_space,
    output logic                           rd_push,
    output stream_axil_pkg::read_resp_t    rd_word
);

    stream_axil_pkg::writer_state_t writer_state;
    stream_axil_pkg::reader_state_t reader_state;

    logic                           aw_valid;
    logic                           w_valid;
    logic                           ar_valid;
    logic [`STREAM_AXIL_ADDR_W-1:0] aw_addr;
    logic [`STREAM_AXIL_DATA_W-1:0] w_data;
    logic [`STREAM_AXIL_ADDR_W-1:0] ar_addr;
    logic                           aw_fire;
    logic                           w_fire;
    logic                           ar_fire;

    assign write_ready    = writer_state == stream_axil_pkg::writer_idle;
    assign read_req_ready = (reader_state == stream_axil_pkg::reader_idle) && rd_space;

    assign aw_fire = aw_valid && bus_rsp.awready;
    assign w_fire  = w_valid && bus_rsp.wready;
    assign ar_fire = ar_valid && bus_rsp.arready;

    always_comb begin
        bus_req.awvalid = aw_valid;
        bus_req.awaddr  = aw_addr;
        bus_req.wvalid  = w_valid;
        bus_req.wdata   = w_data;
        bus_req.bready  = writer_state == stream_axil_pkg::writer_wait_response;
        bus_req.arvalid = ar_valid;
        bus_req.araddr  = ar_addr;
        // No read data is taken while the response buffer is occupied
        bus_req.rready  = (reader_state == stream_axil_pkg::reader_wait_data) && rd_space;
    end

    // Write payload is captured with the stream transfer and held until both channels go out
    always_ff @(posedge clock) begin
        if (write_valid && write_ready) begin
            aw_addr <= write_word.addr;
            w_data  <= write_word.data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            writer_state <= stream_axil_pkg::writer_idle;
            aw_valid     <= 1'b0;
            w_valid      <= 1'b0;
            write_done   <= 1'b0;
            write_error  <= 1'b0;
        end else begin
            write_done <= 1'b0;
            case (writer_state)
                stream_axil_pkg::writer_idle: begin
                    if (write_valid) begin
                        aw_valid     <= 1'b1;
                        w_valid      <= 1'b1;
                        writer_state <= stream_axil_pkg::writer_send_address;
                    end
                end
                stream_axil_pkg::writer_send_address: begin
                    // Data may be taken ahead of the address, together with it, or after it
                    if (w_fire) begin
                        w_valid <= 1'b0;
                    end
                    if (aw_fire) begin
                        aw_valid <= 1'b0;
                        if (w_fire || !w_valid) begin
                            writer_state <= stream_axil_pkg::writer_wait_response;
                        end else begin
                            writer_state <= stream_axil_pkg::writer_send_data;
                        end
                    end
                end
                stream_axil_pkg::writer_send_data: begin
                    if (w_fire) begin
                        w_valid      <= 1'b0;
                        writer_state <= stream_axil_pkg::writer_wait_response;
                    end
                end
                stream_axil_pkg::writer_wait_response: begin
                    if (bus_rsp.bvalid) begin
                        write_done   <= 1'b1;
                        write_error  <= bus_rsp.bresp != stream_axil_pkg::resp_okay;
                        writer_state <= stream_axil_pkg::writer_idle;
                    end
                end
                default: begin
                    writer_state <= stream_axil_pkg::writer_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (read_req_valid && read_req_ready) begin
            ar_addr <= read_req_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            reader_state <= stream_axil_pkg::reader_idle;
            ar_valid     <= 1'b0;
        end else begin
            case (reader_state)
                stream_axil_pkg::reader_idle: begin
                    if (read_req_valid && read_req_ready) begin
                        ar_valid     <= 1'b1;
                        reader_state <= stream_axil_pkg::reader_send_address;
                    end
                end
                stream_axil_pkg::reader_send_address: begin
                    if (ar_fire) begin
                        ar_valid     <= 1'b0;
                        reader_state <= stream_axil_pkg::reader_wait_data;
                    end
                end
                stream_axil_pkg::reader_wait_data: begin
                    if (rd_push) begin
                        reader_state <= stream_axil_pkg::reader_idle;
                    end
                end
                default: begin
                    reader_state <= stream_axil_pkg::reader_idle;
                end
            endcase
        end
    end

    // Read data goes straight into the buffer in the cycle it is accepted
    assign rd_push       = bus_rsp.rvalid && bus_req.rready;
    assign rd_word.data  = bus_rsp.rdata;
    assign rd_word.error = bus_rsp.rresp != stream_axil_pkg::resp_okay;

    aw_valid_held: assert property (@(posedge clock) disable iff (!reset)
        bus_req.awvalid && !bus_rsp.awready |=> bus_req.awvalid);

    w_valid_held: assert property (@(posedge clock) disable iff (!reset)
        bus_req.wvalid && !bus_rsp.wready |=> bus_req.wvalid);

    ar_valid_held: assert property (@(posedge clock) disable iff (!reset)
        bus_req.arvalid && !bus_rsp.arready |=> bus_req.arvalid);

    // A pushed word occupies the buffer, so the next beat has to wait for space
    push_fills_buffer: assert property (@(posedge clock) disable iff (!reset)
        rd_push |=> !rd_space);

endmodule

/* src/axil_reg_bank.sv */
/*
 * AXI-Lite register bank with word-spaced decode from a fixed base.
 * Unmapped writes are dropped and any unmapped access answers with a decode error.
 */

`include "stream_axil_settings.svh"

module axil_reg_bank (
    input  logic                       clock,
    input  logic                       reset,
    input  stream_axil_pkg::axil_req_t bus_req,
    output stream_axil_pkg::axil_rsp_t bus_rsp
);

    localparam int IDX_W = $clog2(`STREAM_AXIL_REG_COUNT);

    logic [`STREAM_AXIL_DATA_W-1:0] regs [`STREAM_AXIL_REG_COUNT];
    logic                           aw_held;
    logic                           w_held;
    logic [`STREAM_AXIL_ADDR_W-1:0] aw_addr;
    logic [`STREAM_AXIL_DATA_W-1:0] w_data;
    logic                           bvalid;
    stream_axil_pkg::axil_resp_t    bresp;
    logic                           rvalid;
    logic [`STREAM_AXIL_DATA_W-1:0] rdata;
    stream_axil_pkg::axil_resp_t    rresp;
    logic                           aw_fire;
    logic                           w_fire;
    logic                           ar_fire;
    logic                           commit;

    function automatic logic addr_hit(input logic [`STREAM_AXIL_ADDR_W-1:0] addr);
        logic [`STREAM_AXIL_ADDR_W-1:0] offset;
        offset = addr - `STREAM_AXIL_REG_BASE;
        return (offset[1:0] == 2'b00) && ((offset >> 2) < `STREAM_AXIL_REG_COUNT);
    endfunction

    function automatic logic [IDX_W-1:0] addr_index(input logic [`STREAM_AXIL_ADDR_W-1:0] addr);
        logic [`STREAM_AXIL_ADDR_W-1:0] offset;
        offset = addr - `STREAM_AXIL_REG_BASE;
        return offset[IDX_W+1:2];
    endfunction

    assign aw_fire = bus_req.awvalid && !aw_held;
    assign w_fire  = bus_req.wvalid && !w_held;
    assign ar_fire = bus_req.arvalid && !rvalid;
    // A write completes only once both halves have arrived and the last response is gone
    assign commit  = aw_held && w_held && !bvalid;

    always_ff @(posedge clock) begin
        if (aw_fire) begin
            aw_addr <= bus_req.awaddr;
        end
        if (w_fire) begin
            w_data <= bus_req.wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= stream_axil_pkg::resp_okay;
            for (int i = 0; i < `STREAM_AXIL_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (aw_fire) begin
                aw_held <= 1'b1;
            end
            if (w_fire) begin
                w_held <= 1'b1;
            end
            if (commit) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                bvalid  <= 1'b1;
                if (addr_hit(aw_addr)) begin
                    regs[addr_index(aw_addr)] <= w_data;
                    bresp <= stream_axil_pkg::resp_okay;
                end else begin
                    bresp <= stream_axil_pkg::resp_decerr;
                end
            end else if (bvalid && bus_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (rvalid && bus_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (ar_fire) begin
            if (addr_hit(bus_req.araddr)) begin
                rdata <= regs[addr_index(bus_req.araddr)];
                rresp <= stream_axil_pkg::resp_okay;
            end else begin
                rdata <= '0;
                rresp <= stream_axil_pkg::resp_decerr;
            end
        end
    end

    always_comb begin
        bus_rsp.awready = !aw_held;
        bus_rsp.wready  = !w_held;
        bus_rsp.bvalid  = bvalid;
        bus_rsp.bresp   = bresp;
        bus_rsp.arready = !rvalid;
        bus_rsp.rvalid  = rvalid;
        bus_rsp.rdata   = rdata;
        bus_rsp.rresp   = rresp;
    end

    bvalid_after_both: assert property (@(posedge clock) disable iff (!reset)
        $rose(bvalid) |-> $past(aw_held && w_held));

endmodule

/* src/read_response_buffer.sv */
/*
 * One-entry holding register between the bus read channel and the outgoing response stream.
 * rd_space tells the bridge when it may accept the next read beat.
 */

module read_response_buffer (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        rd_push,
    input  stream_axil_pkg::read_resp_t rd_word,
    output logic                        rd_space,
    output logic                        resp_valid,
    input  logic                        resp_ready,
    output stream_axil_pkg::read_resp_t resp_word
);

    logic full;

    assign rd_space   = !full;
    assign resp_valid = full;

    always_ff @(posedge clock) begin
        if (!reset) begin
            full <= 1'b0;
        end else if (rd_push) begin
            full <= 1'b1;
        end else if (full && resp_ready) begin
            full <= 1'b0;
        end
    end

    // The word is loaded only while empty, so it cannot change under back-pressure
    always_ff @(posedge clock) begin
        if (rd_push) begin
            resp_word <= rd_word;
        end
    end

    resp_stable: assert property (@(posedge clock) disable iff (!reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_word));

endmodule

/* src/stream_axil_top.sv */
/*
 * Top level of the stream to AXI-Lite bridge with its register bank and read response buffer.
 */

`include "stream_axil_settings.svh"

module stream_axil_top (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           write_valid,
    input  stream_axil_pkg::write_word_t   write_word,
    output logic                           write_ready,
    input  logic                           read_req_valid,
    input  logic [`STREAM_AXIL_ADDR_W-1:0] read_req_addr,
    output logic                           read_req_ready,
    output logic                           resp_valid,
    input  logic                           resp_ready,
    output stream_axil_pkg::read_resp_t    resp_word,
    output logic                           write_done,
    output logic                           write_error
);

    stream_axil_pkg::axil_req_t  bus_req;
    stream_axil_pkg::axil_rsp_t  bus_rsp;
    stream_axil_pkg::read_resp_t rd_word;
    logic                        rd_push;
    logic                        rd_space;

    axil_bridge_ctrl i_bridge (
        .clock          (clock),
        .reset          (reset),
        .write_valid    (write_valid),
        .write_word     (write_word),
        .write_ready    (write_ready),
        .read_req_valid (read_req_valid),
        .read_req_addr  (read_req_addr),
        .read_req_ready (read_req_ready),
        .bus_req        (bus_req),
        .bus_rsp        (bus_rsp),
        .write_done     (write_done),
        .write_error    (write_error),
        .rd_space       (rd_space),
        .rd_push        (rd_push),
        .rd_word        (rd_word)
    );

    axil_reg_bank i_reg_bank (
        .clock   (clock),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    read_response_buffer i_resp_buffer (
        .clock      (clock),
        .reset      (reset),
        .rd_push    (rd_push),
        .rd_word    (rd_word),
        .rd_space   (rd_space),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_word  (resp_word)
    );

endmodule

/* verif/tb_stream_axil.sv */
/*
 * Testbench for the stream to AXI-Lite bridge. Replays the vector file, sweeps the register
 * bank after reset and at the end, and stalls the response stream at random.
 */

`include "stream_axil_settings.svh"

module tb_stream_axil;

    timeunit 1ns;
    timeprecision 100ps;

    logic                           clock = 1'b0;
    logic                           reset;
    logic                           write_valid;
    stream_axil_pkg::write_word_t   write_word;
    logic                           write_ready;
    logic                           read_req_valid;
    logic [`STREAM_AXIL_ADDR_W-1:0] read_req_addr;
    logic                           read_req_ready;
    logic                           resp_valid;
    logic                           resp_ready;
    stream_axil_pkg::read_resp_t    resp_word;
    logic                           write_done;
    logic                           write_error;

    // One entry per vector line
    logic [7:0]                     op_q[$];
    logic [`STREAM_AXIL_ADDR_W-1:0] addr_q[$];
    logic [`STREAM_AXIL_DATA_W-1:0] wdata_q[$];
    logic [`STREAM_AXIL_DATA_W-1:0] rdata_q[$];
    logic                           err_q[$];

    stream_axil_pkg::read_resp_t    expected_q[$];
    stream_axil_pkg::read_resp_t    expected_word;
    stream_axil_pkg::read_resp_t    held_word;
    logic [`STREAM_AXIL_DATA_W-1:0] shadow [`STREAM_AXIL_REG_COUNT];
    logic                           hold_pending = 1'b0;
    logic                           next_ready;
    int                             reads_issued = 0;
    int                             resp_count = 0;
    int                             cycle_count = 0;
    int                             cycle_limit = 0;

    stream_axil_top i_dut (
        .clock          (clock),
        .reset          (reset),
        .write_valid    (write_valid),
        .write_word     (write_word),
        .write_ready    (write_ready),
        .read_req_valid (read_req_valid),
        .read_req_addr  (read_req_addr),
        .read_req_ready (read_req_ready),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .resp_word      (resp_word),
        .write_done     (write_done),
        .write_error    (write_error)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run made no progress within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic load_vectors();
        int                             fd;
        int                             fields;
        string                          line;
        logic [7:0]                     op;
        logic [`STREAM_AXIL_ADDR_W-1:0] addr;
        logic [`STREAM_AXIL_DATA_W-1:0] wdata;
        logic [`STREAM_AXIL_DATA_W-1:0] rdata;
        logic [31:0]                    err;
        fd = $fopen("verif/stream_axil_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("Could not open the vector file verif/stream_axil_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines carry no operation
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %h %h", op, addr, wdata, rdata, err);
            if (fields != 5) begin
                report_failure({"Malformed vector line: ", line});
            end
            op_q.push_back(op);
            addr_q.push_back(addr);
            wdata_q.push_back(wdata);
            rdata_q.push_back(rdata);
            err_q.push_back(err[0]);
        end
        $fclose(fd);
    endtask

    // Called on a falling edge, returns on the falling edge after the request transfer
    task automatic issue_read(input logic [`STREAM_AXIL_ADDR_W-1:0] addr,
                              input logic [`STREAM_AXIL_DATA_W-1:0] exp_data,
                              input logic exp_err);
        stream_axil_pkg::read_resp_t exp_word;
        exp_word.data  = exp_data;
        exp_word.error = exp_err;
        expected_q.push_back(exp_word);
        reads_issued++;
        read_req_valid = 1'b1;
        read_req_addr  = addr;
        while (!read_req_ready) @(negedge clock);
        @(negedge clock);
        read_req_valid = 1'b0;
    endtask

    task automatic issue_write(input logic [`STREAM_AXIL_ADDR_W-1:0] addr,
                               input logic [`STREAM_AXIL_DATA_W-1:0] data,
                               input logic exp_err);
        int idx;
        // Reads give no ordering against a later write, so outstanding ones finish first
        while (expected_q.size() != 0) @(negedge clock);
        write_valid     = 1'b1;
        write_word.addr = addr;
        write_word.data = data;
        while (!write_ready) @(negedge clock);
        @(negedge clock);
        write_valid = 1'b0;
        while (!write_done) @(negedge clock);
        check_value("write_error", exp_err, write_error);
        if (!exp_err) begin
            idx = (addr - `STREAM_AXIL_REG_BASE) >> 2;
            shadow[idx] = data;
        end
    endtask

    task automatic sweep_registers();
        for (int i = 0; i < `STREAM_AXIL_REG_COUNT; i++) begin
            issue_read(`STREAM_AXIL_REG_BASE + 4 * i, shadow[i], 1'b0);
        end
    endtask

    // Transfers on the response stream, counted at the edge where they happen
    always @(posedge clock) begin
        if (reset && resp_valid && resp_ready) begin
            resp_count++;
        end
    end

    // Response side with random back-pressure and a stability check while stalled
    always @(negedge clock) begin
        if (reset) begin
            if (hold_pending) begin
                check_value("resp_valid", 1'b1, resp_valid);
                check_value("resp_word", held_word, resp_word);
            end
            next_ready = $urandom % 2;
            if (resp_valid && next_ready) begin
                if (expected_q.size() == 0) begin
                    report_failure("A read response arrived with no read outstanding");
                end
                expected_word = expected_q.pop_front();
                check_value("resp_word.data", expected_word.data, resp_word.data);
                check_value("resp_word.error", expected_word.error, resp_word.error);
            end
            hold_pending = resp_valid && !next_ready;
            held_word    = resp_word;
            resp_ready   = next_ready;
        end
    end

    initial begin
        void'($urandom(97));
        reset          = 1'b0;
        write_valid    = 1'b0;
        write_word     = '0;
        read_req_valid = 1'b0;
        read_req_addr  = '0;
        resp_ready     = 1'b0;
        for (int i = 0; i < `STREAM_AXIL_REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        load_vectors();
        cycle_limit = 50 * (op_q.size() + 2 * `STREAM_AXIL_REG_COUNT) + 100;
        repeat (3) @(negedge clock);
        reset = 1'b1;
        check_value("resp_valid", 1'b0, resp_valid);
        check_value("write_done", 1'b0, write_done);
        check_value("write_ready", 1'b1, write_ready);
        check_value("read_req_ready", 1'b1, read_req_ready);
        sweep_registers();
        foreach (op_q[i]) begin
            if (op_q[i] == "W") begin
                issue_write(addr_q[i], wdata_q[i], err_q[i]);
            end else begin
                issue_read(addr_q[i], rdata_q[i], err_q[i]);
            end
        end
        // The unmapped writes must have left every register as the mapped writes set it
        sweep_registers();
        while (expected_q.size() != 0) @(negedge clock);
        // Let the last word leave, then nothing else may follow it
        repeat (4) @(negedge clock);
        check_value("resp_valid", 1'b0, resp_valid);
        check_value("response_count", reads_issued, resp_count);
        $display("TEST OK");
        $finish;
    end

endmodule

/* verif/stream_axil_vectors.txt */
# columns: op (W write, R read), address, write data, expected read data, expected error flag
# all values in hex, register 0 sits at 00001000 and registers are 4 bytes apart
W 00001000 a5a50001 00000000 0
R 00001000 00000000 a5a50001 0
W 0000103c 5a5a000f 00000000 0
R 0000103c 00000000 5a5a000f 0
W 00001004 12345678 00000000 0
W 00001008 9abcdef0 00000000 0
R 00001004 00000000 12345678 0
R 00001008 00000000 9abcdef0 0
R 00001000 00000000 a5a50001 0
W 00001040 deadbeef 00000000 1
W 00001002 cafef00d 00000000 1
W 00000ffc 0badc0de 00000000 1
R 00001040 00000000 00000000 1
R 00002000 00000000 00000000 1
R 00000000 00000000 00000000 1
R 00001003 00000000 00000000 1
W 00001004 ffffffff 00000000 0
R 00001004 00000000 ffffffff 0
R 0000100c 00000000 00000000 0
R 0000103c 00000000 5a5a000f 0

/* stream_axil.f */
+incdir+src
src/stream_axil_pkg.sv
src/axil_bridge_ctrl.sv
src/axil_reg_bank.sv
src/read_response_buffer.sv
src/stream_axil_top.sv
verif/tb_stream_axil.sv

/* Bender.yml */
package:
  name: stream_axil

sources:
  - include_dirs:
      - src
    files:
      - src/stream_axil_pkg.sv
      - src/axil_bridge_ctrl.sv
      - src/axil_reg_bank.sv
      - src/read_response_buffer.sv
      - src/stream_axil_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_stream_axil.sv
